// ==== files.f ====
+incdir+include
source/agcPkg.sv
source/agcBusSlave.sv
source/agcLoopRegs.sv
source/agcLoopFilter.sv
source/agcLoop.sv
sim/agcLoopTb.sv

// ==== Makefile ====
TOOL      := verilator
FLAGS     := --binary --timing --assert
TOP       := agcLoopTb
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)."; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/agcLoopTb.sv ====
// Table-driven testbench for the AGC loop. Burst samples are random with a fixed
// seed; a filter model predicts the integrator and gain after every burst.
`timescale 1ns/1ps
`default_nettype none

`include "agcAddressMap.svh"

module agcLoopTb import agcPkg::*; ();

    localparam int          GAIN_WIDTH      = 8;
    localparam realtime     CLK_PERIOD      = 4.0;
    localparam int          NUM_STEPS       = 35;
    localparam int          WATCHDOG_CYCLES = NUM_STEPS * 64;
    localparam int unsigned SEED            = 32'h55f1_bb01;

    typedef enum logic [1:0] {BUS_WRITE, BUS_READ, SAMPLE_BURST} stepKindT;

    typedef struct packed {
        stepKindT   kind;
        busAddrT    addr;
        busDataT    data;                      // Write data, expected read data, or {spread, base}.
        byteEnT     byteEn;
        logic [7:0] count;
    } stepT;

    logic                  busClk;
    logic                  arstN;
    logic                  req;
    busReqT                busReq;
    logic                  ack;
    busDataT               rdata;
    magT                   sample;
    logic                  sampleValid;
    logic [GAIN_WIDTH-1:0] gain;

    stepT    steps [NUM_STEPS];
    agcCtrlT modelCtrl;
    integT   modelInteg;
    int      errorCount;

    agcLoop #(
        .GAIN_WIDTH (GAIN_WIDTH)
    ) u_dut (
        .busClk      (busClk),
        .arstN       (arstN),
        .req         (req),
        .busReq      (busReq),
        .ack         (ack),
        .rdata       (rdata),
        .sample      (sample),
        .sampleValid (sampleValid),
        .gain        (gain)
    );

    initial begin
        busClk = 1'b0;
        forever #(CLK_PERIOD / 2) busClk = ~busClk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run is stuck.", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    // ************************************************************************
    // Compare tasks and reference model
    // ************************************************************************

    task automatic checkData(input string name, input busDataT got, input busDataT exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkGain(input string name, input logic [GAIN_WIDTH-1:0] got,
                             input logic [GAIN_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    task automatic applyWrite(input busAddrT addr, input busDataT data, input byteEnT be);
        if (addr == `AGC_CONTROL && be[0]) begin
            modelCtrl.zeroError   = data[0];
            modelCtrl.invertError = data[1];
        end
        if (addr == `AGC_SETPOINT && be[0]) begin
            modelCtrl.setpoint = data[7:0];
        end
        if (addr == `AGC_GAINS && be[0]) begin
            modelCtrl.posErrorGain = data[4:0];
        end
        if (addr == `AGC_GAINS && be[2]) begin
            modelCtrl.negErrorGain = data[20:16];
        end
        for (int lane = 0; lane < 4; lane++) begin
            if (be[lane] && addr == `AGC_ULIMIT) begin
                modelCtrl.upperLimit[8*lane +: 8] = data[8*lane +: 8];
            end else if (be[lane] && addr == `AGC_LLIMIT) begin
                modelCtrl.lowerLimit[8*lane +: 8] = data[8*lane +: 8];
            end
        end
    endtask

    task automatic modelSample(input magT value);
        int     error;
        longint scaled;
        longint sum;
        error = int'(modelCtrl.setpoint) - int'(value);
        if (modelCtrl.zeroError) begin
            error = 0;
        end else if (modelCtrl.invertError) begin
            error = -error;
        end
        scaled = longint'(error);
        scaled = (error < 0) ? (scaled <<< modelCtrl.negErrorGain)
                             : (scaled <<< modelCtrl.posErrorGain);
        sum = longint'(modelInteg) + scaled;
        if (sum > longint'($signed(modelCtrl.upperLimit))) begin
            modelInteg = modelCtrl.upperLimit;
        end else if (sum < longint'($signed(modelCtrl.lowerLimit))) begin
            modelInteg = modelCtrl.lowerLimit;
        end else begin
            modelInteg = integT'(sum);
        end
    endtask

    // ************************************************************************
    // Bus and sample drivers
    // ************************************************************************

    task automatic busAccess(input busAddrT addr, input busDataT data, input byteEnT be,
                             input logic isWrite, output busDataT readBack);
        @(posedge busClk);
        req    <= 1'b1;
        busReq <= '{addr: addr, wdata: data, byteEn: be, write: isWrite};
        @(negedge busClk);
        while (!ack) @(negedge busClk);
        readBack = rdata;
        @(posedge busClk);
        req <= 1'b0;
        @(negedge busClk);
        while (ack) @(negedge busClk);
    endtask

    task automatic runBurst(input magT base, input magT spread, input int count);
        magT value;
        for (int i = 0; i < count; i++) begin
            value = base + magT'($urandom % (int'(spread) + 1));
            @(posedge busClk);
            sample      <= value;
            sampleValid <= 1'b1;
            modelSample(value);
        end
        @(posedge busClk);
        sampleValid <= 1'b0;
        repeat (2) @(posedge busClk);          // Last sample has reached the integrator.
        @(negedge busClk);
        checkGain("gain", gain, modelInteg[31 -: GAIN_WIDTH]);
    endtask

    function automatic stepT makeStep(input stepKindT kind, input busAddrT addr,
                                      input busDataT data, input byteEnT be, input int count);
        stepT s;
        s = '{kind: kind, addr: addr, data: data, byteEn: be, count: 8'(count)};
        return s;
    endfunction

    task automatic runStep(input int idx, input stepT step);
        busDataT readBack;
        busDataT expected;
        int      errorsBefore;
        string   kindName;
        errorsBefore = errorCount;
        case (step.kind)
            BUS_WRITE: begin
                kindName = "write";
                busAccess(step.addr, step.data, step.byteEn, 1'b1, readBack);
                applyWrite(step.addr, step.data, step.byteEn);
            end
            BUS_READ: begin
                kindName = "read";
                busAccess(step.addr, '0, '0, 1'b0, readBack);
                // The integrator is live, so its value comes from the model.
                expected = (step.addr == `AGC_INTEGRATOR) ? busDataT'(modelInteg) : step.data;
                checkData($sformatf("rdata[0x%03h]", step.addr), readBack, expected);
            end
            default: begin
                kindName = "burst";
                runBurst(step.data[7:0], step.data[15:8], int'(step.count));
                busAccess(`AGC_INTEGRATOR, '0, '0, 1'b0, readBack);
                checkData("rdata[INTEGRATOR]", readBack, busDataT'(modelInteg));
            end
        endcase
        $display("step %0d %s addr 0x%03h: %s", idx, kindName, step.addr,
                 (errorCount == errorsBefore) ? "ok" : "failed");
    endtask

    // ************************************************************************
    // Stimulus table and main sequence
    // ************************************************************************

    initial begin
        arstN       = 1'b0;
        req         = 1'b0;
        busReq      = '0;
        sample      = '0;
        sampleValid = 1'b0;
        errorCount  = 0;
        modelInteg  = '0;
        modelCtrl   = '{setpoint: '0, zeroError: 1'b0, invertError: 1'b0,
                        posErrorGain: '0, negErrorGain: '0,
                        upperLimit: 32'sh7FFF_FFFF, lowerLimit: 32'sh8000_0000};
        void'($urandom(SEED));

        steps[0]  = makeStep(BUS_READ, `AGC_CONTROL, 32'h0, '0, 0);    // Reset readback.
        steps[1]  = makeStep(BUS_READ, `AGC_SETPOINT, 32'h0, '0, 0);
        steps[2]  = makeStep(BUS_READ, `AGC_GAINS, 32'h0, '0, 0);
        steps[3]  = makeStep(BUS_READ, `AGC_ULIMIT, 32'h7FFF_FFFF, '0, 0);
        steps[4]  = makeStep(BUS_READ, `AGC_LLIMIT, 32'h8000_0000, '0, 0);
        steps[5]  = makeStep(BUS_READ, `AGC_INTEGRATOR, 32'h0, '0, 0);
        steps[6]  = makeStep(BUS_READ, 13'h018, 32'h0, '0, 0);
        steps[7]  = makeStep(BUS_READ, 13'h1FFC, 32'h0, '0, 0);
        steps[8]  = makeStep(BUS_WRITE, `AGC_ULIMIT, 32'h1234_5678, 4'b0101, 0); // Lanes.
        steps[9]  = makeStep(BUS_READ, `AGC_ULIMIT, 32'h7F34_FF78, '0, 0);
        steps[10] = makeStep(BUS_WRITE, `AGC_GAINS, 32'h0013_0007, 4'b0001, 0);
        steps[11] = makeStep(BUS_READ, `AGC_GAINS, 32'h0000_0007, '0, 0);
        steps[12] = makeStep(BUS_WRITE, `AGC_GAINS, 32'h0003_001F, 4'b0100, 0);
        steps[13] = makeStep(BUS_READ, `AGC_GAINS, 32'h0003_0007, '0, 0);
        steps[14] = makeStep(BUS_WRITE, `AGC_INTEGRATOR, 32'h1234_5678, 4'b1111, 0);
        steps[15] = makeStep(BUS_READ, `AGC_INTEGRATOR, 32'h0, '0, 0);
        steps[16] = makeStep(BUS_WRITE, `AGC_ULIMIT, 32'h7FFF_FFFF, 4'b1111, 0); // Integrate.
        steps[17] = makeStep(BUS_WRITE, `AGC_SETPOINT, 32'h0000_0080, 4'b0001, 0);
        steps[18] = makeStep(BUS_WRITE, `AGC_GAINS, 32'h0012_0014, 4'b0101, 0);
        steps[19] = makeStep(BUS_READ, `AGC_GAINS, 32'h0012_0014, '0, 0);
        steps[20] = makeStep(SAMPLE_BURST, '0, 32'h0000_2020, '0, 12);
        steps[21] = makeStep(SAMPLE_BURST, '0, 32'h0000_3FC0, '0, 16);
        steps[22] = makeStep(BUS_WRITE, `AGC_ULIMIT, 32'h0100_0000, 4'b1111, 0); // Clamp.
        steps[23] = makeStep(BUS_WRITE, `AGC_LLIMIT, 32'hFF00_0000, 4'b1111, 0);
        steps[24] = makeStep(SAMPLE_BURST, '0, 32'h0000_1000, '0, 8);
        steps[25] = makeStep(SAMPLE_BURST, '0, 32'h0000_0FF0, '0, 12);
        steps[26] = makeStep(BUS_WRITE, `AGC_LLIMIT, 32'h8000_0000, 4'b1111, 0); // Controls.
        steps[27] = makeStep(BUS_WRITE, `AGC_ULIMIT, 32'h7FFF_FFFF, 4'b1111, 0);
        steps[28] = makeStep(BUS_WRITE, `AGC_CONTROL, 32'h0000_0001, 4'b0001, 0);
        steps[29] = makeStep(BUS_READ, `AGC_CONTROL, 32'h0000_0001, '0, 0);
        steps[30] = makeStep(SAMPLE_BURST, '0, 32'h0000_FF00, '0, 10);
        steps[31] = makeStep(BUS_WRITE, `AGC_CONTROL, 32'h0000_0002, 4'b0001, 0);
        steps[32] = makeStep(SAMPLE_BURST, '0, 32'h0000_1010, '0, 10);
        steps[33] = makeStep(BUS_WRITE, `AGC_CONTROL, 32'h0000_0000, 4'b0001, 0);
        steps[34] = makeStep(SAMPLE_BURST, '0, 32'h0000_1010, '0, 6);

        repeat (8) @(posedge busClk);
        arstN <= 1'b1;
        for (int i = 0; i < NUM_STEPS; i++) begin
            runStep(i, steps[i]);
        end

        $display("%0d steps run, %0d errors", NUM_STEPS, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/agcLoop.sv ====
// AGC loop top level: bus slave, control registers and loop filter.
// GAIN_WIDTH must not exceed the 32-bit integrator width.
`timescale 1ns/1ps
`default_nettype none

module agcLoop import agcPkg::*; #(
    parameter int GAIN_WIDTH = 8
) (
    input  logic                  busClk,
    input  logic                  arstN,
    input  logic                  req,
    input  busReqT                busReq,
    output logic                  ack,
    output busDataT               rdata,
    input  magT                   sample,
    input  logic                  sampleValid,
    output logic [GAIN_WIDTH-1:0] gain
);

    regAccessT access;
    logic      accessEn;
    busDataT   readData;
    agcCtrlT   ctrl;
    integT     integ;

    // ************************************************************************
    // Bus side
    // ************************************************************************

    agcBusSlave u_busSlave (
        .busClk   (busClk),
        .arstN    (arstN),
        .req      (req),
        .busReq   (busReq),
        .ack      (ack),
        .rdata    (rdata),
        .access   (access),
        .accessEn (accessEn),
        .readData (readData)
    );

    agcLoopRegs u_loopRegs (
        .busClk   (busClk),
        .arstN    (arstN),
        .access   (access),
        .accessEn (accessEn),
        .readData (readData),
        .ctrl     (ctrl),
        .integ    (integ)
    );

    // ************************************************************************
    // Loop filter
    // ************************************************************************

    agcLoopFilter #(
        .GAIN_WIDTH (GAIN_WIDTH)
    ) u_loopFilter (
        .busClk      (busClk),
        .arstN       (arstN),
        .ctrl        (ctrl),
        .sample      (sample),
        .sampleValid (sampleValid),
        .integ       (integ),
        .gain        (gain)
    );

endmodule

`default_nettype wire

// ==== source/agcLoopFilter.sv ====
// AGC loop filter with one pipeline stage: a sample taken at edge N moves the
// integrator at edge N+1. Clamping assumes lowerLimit <= upperLimit.
`timescale 1ns/1ps
`default_nettype none

module agcLoopFilter import agcPkg::*; #(
    parameter int GAIN_WIDTH = 8
) (
    input  logic                  busClk,
    input  logic                  arstN,
    input  agcCtrlT               ctrl,
    input  magT                   sample,
    input  logic                  sampleValid,
    output integT                 integ,
    output logic [GAIN_WIDTH-1:0] gain
);

    localparam int INTEG_W = $bits(integT);
    localparam int ERR_W   = $bits(magT) + 1;
    // Error shifted by up to 31 places, plus a carry bit for the add.
    localparam int SUM_W   = ERR_W + 2 ** $bits(gainShiftT);

    logic signed [ERR_W-1:0] rawError;
    logic signed [ERR_W-1:0] error;
    logic signed [SUM_W-1:0] errorWide;
    logic signed [SUM_W-1:0] scaledError;
    logic signed [SUM_W-1:0] scaledQ;
    logic                    validQ;
    logic signed [SUM_W-1:0] sum;
    integT                   upperLim;
    integT                   lowerLim;
    integT                   clamped;

    // ************************************************************************
    // Stage 1: error and gain shift
    // ************************************************************************

    assign rawError = $signed({1'b0, ctrl.setpoint}) - $signed({1'b0, sample});

    always_comb begin
        if (ctrl.zeroError) begin
            error = '0;
        end else if (ctrl.invertError) begin
            error = -rawError;
        end else begin
            error = rawError;
        end
    end

    assign errorWide   = SUM_W'(error);        // Sign extended.
    assign scaledError = error[ERR_W-1] ? (errorWide <<< ctrl.negErrorGain)
                                        : (errorWide <<< ctrl.posErrorGain);

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= sampleValid;
        end
    end

    always_ff @(posedge busClk) begin
        if (sampleValid) begin
            scaledQ <= scaledError;
        end
    end

    // ************************************************************************
    // Stage 2: integrate and clamp
    // ************************************************************************

    assign upperLim = ctrl.upperLimit;
    assign lowerLim = ctrl.lowerLimit;

    // Wide enough that the sum never wraps before the clamp.
    assign sum = SUM_W'(integ) + scaledQ;

    always_comb begin
        if (sum > SUM_W'(upperLim)) begin
            clamped = upperLim;
        end else if (sum < SUM_W'(lowerLim)) begin
            clamped = lowerLim;
        end else begin
            clamped = sum[INTEG_W-1:0];
        end
    end

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            integ <= '0;
        end else if (validQ) begin
            integ <= clamped;
        end
    end

    // Gain follows the top bits of the integrator.
    assign gain = integ[INTEG_W-1 -: GAIN_WIDTH];

    // The integrator lands inside the limits that were in force for the update.
    assert property (@(posedge busClk) disable iff (!arstN)
        validQ && (lowerLim <= upperLim) |=>
            (integ >= $past(lowerLim)) && (integ <= $past(upperLim)));

endmodule

`default_nettype wire

// ==== source/agcLoopRegs.sv ====
// AGC loop control registers with byte-lane writes.
// Unmapped addresses and reserved bits read as zero; the integrator is read only.
`timescale 1ns/1ps
`default_nettype none

`include "agcAddressMap.svh"

module agcLoopRegs import agcPkg::*; (
    input  logic      busClk,
    input  logic      arstN,
    input  regAccessT access,
    input  logic      accessEn,
    output busDataT   readData,
    output agcCtrlT   ctrl,
    input  integT     integ
);

    localparam agcCtrlT CTRL_DEFAULT = '{
        setpoint:     '0,
        zeroError:    1'b0,
        invertError:  1'b0,
        posErrorGain: '0,
        negErrorGain: '0,
        upperLimit:   32'sh7FFF_FFFF,
        lowerLimit:   32'sh8000_0000
    };

    agcCtrlT ctrlQ;
    byteEnT  lanes;

    assign lanes = accessEn ? access.wrLanes : '0;

    // ************************************************************************
    // Byte-lane writes
    // ************************************************************************

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            ctrlQ <= CTRL_DEFAULT;
        end else begin
            // The limits take every lane.
            for (int lane = 0; lane < 4; lane++) begin
                if (lanes[lane]) begin
                    case (access.addr)
                        `AGC_ULIMIT: begin
                            ctrlQ.upperLimit[8*lane +: 8] <= access.wdata[8*lane +: 8];
                        end
                        `AGC_LLIMIT: begin
                            ctrlQ.lowerLimit[8*lane +: 8] <= access.wdata[8*lane +: 8];
                        end
                        default: ;
                    endcase
                end
            end

            if (lanes[0]) begin
                case (access.addr)
                    `AGC_CONTROL: begin
                        ctrlQ.zeroError   <= access.wdata[0];
                        ctrlQ.invertError <= access.wdata[1];
                    end
                    `AGC_SETPOINT: begin
                        ctrlQ.setpoint <= access.wdata[7:0];
                    end
                    `AGC_GAINS: begin
                        ctrlQ.posErrorGain <= access.wdata[4:0];
                    end
                    default: ;
                endcase
            end

            if (lanes[2] && access.addr == `AGC_GAINS) begin
                ctrlQ.negErrorGain <= access.wdata[20:16];
            end
        end
    end

    assign ctrl = ctrlQ;

    // ************************************************************************
    // Readback
    // ************************************************************************

    always_comb begin
        case (access.addr)
            `AGC_CONTROL: begin
                readData = {30'b0, ctrlQ.invertError, ctrlQ.zeroError};
            end
            `AGC_SETPOINT: begin
                readData = {24'b0, ctrlQ.setpoint};
            end
            `AGC_GAINS: begin
                readData = {11'b0, ctrlQ.negErrorGain, 11'b0, ctrlQ.posErrorGain};
            end
            `AGC_ULIMIT: begin
                readData = ctrlQ.upperLimit;
            end
            `AGC_LLIMIT: begin
                readData = ctrlQ.lowerLimit;
            end
            `AGC_INTEGRATOR: begin
                readData = integ;              // Live value from the filter.
            end
            default: begin
                readData = '0;
            end
        endcase
    end

    // The slave only presents write lanes during its access strobe.
    assert property (@(posedge busClk) disable iff (!arstN)
        !accessEn |-> access.wrLanes == '0);

endmodule

`default_nettype wire

// ==== source/agcBusSlave.sv ====
// Four-phase req/ack slave. busReq must stay stable while req is high, and
// req may rise again only after ack has fallen.
`timescale 1ns/1ps
`default_nettype none

module agcBusSlave import agcPkg::*; (
    input  logic      busClk,
    input  logic      arstN,
    input  logic      req,
    input  busReqT    busReq,
    output logic      ack,
    output busDataT   rdata,
    output regAccessT access,
    output logic      accessEn,
    input  busDataT   readData
);

    // ************************************************************************
    // Access toward the register block
    // ************************************************************************

    // A request is new while ack is still low. The access lands on the
    // same edge that raises ack, so accessEn is one cycle wide.
    assign accessEn = req && !ack;

    always_comb begin
        access.addr    = busReq.addr;
        access.wdata   = busReq.wdata;
        access.wrLanes = '0;
        if (accessEn && busReq.write) begin
            access.wrLanes = busReq.byteEn;
        end
    end

    // ************************************************************************
    // Handshake
    // ************************************************************************

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            ack <= 1'b0;
        end else if (accessEn) begin
            ack <= 1'b1;
        end else if (!req) begin
            ack <= 1'b0;                       // Master has released the request.
        end
    end

    // Read data is taken with the access and held while ack is high.
    always_ff @(posedge busClk) begin
        if (accessEn) begin
            rdata <= readData;
        end
    end

    // The master holds the request stable for as long as req stays high.
    assert property (@(posedge busClk) disable iff (!arstN)
        req && $past(req) |-> $stable(busReq));

    // The master keeps req high until it has seen ack.
    assert property (@(posedge busClk) disable iff (!arstN)
        req && !ack |=> req);

endmodule

`default_nettype wire

// ==== source/agcPkg.sv ====
// Types shared by the AGC loop blocks.
// The integrator and both limits are signed 32-bit two's complement values.
`default_nettype none

package agcPkg;

    // ************************************************************************
    // Vector types
    // ************************************************************************

    typedef logic [12:0]        busAddrT;
    typedef logic [31:0]        busDataT;
    typedef logic [3:0]         byteEnT;       // Bit n covers data bits 8n+7 to 8n.
    typedef logic [7:0]         magT;          // Unsigned, also used for the setpoint.
    typedef logic [4:0]         gainShiftT;
    typedef logic signed [31:0] integT;

    // ************************************************************************
    // Structs
    // ************************************************************************

    // What the master holds stable while req is high.
    typedef struct packed {
        busAddrT addr;
        busDataT wdata;
        byteEnT  byteEn;
        logic    write;
    } busReqT;

    typedef struct packed {
        busAddrT addr;
        busDataT wdata;
        byteEnT  wrLanes;                      // All zero for a read.
    } regAccessT;

    typedef struct packed {
        magT       setpoint;
        logic      zeroError;
        logic      invertError;
        gainShiftT posErrorGain;
        gainShiftT negErrorGain;
        integT     upperLimit;
        integT     lowerLimit;
    } agcCtrlT;

endpackage

`default_nettype wire

// ==== include/agcAddressMap.svh ====
// Byte addresses of the AGC loop registers in the 13-bit bus space.
// All registers are 32 bits wide and word aligned.
`ifndef AGC_ADDRESS_MAP_SVH
`define AGC_ADDRESS_MAP_SVH

// ****************************************************************************
// Loop control registers
// ****************************************************************************

// Bit 0 is zeroError and bit 1 is invertError.
`define AGC_CONTROL     13'h000
`define AGC_SETPOINT    13'h004
// Positive gain in bits 4:0, negative gain in bits 20:16.
`define AGC_GAINS       13'h008
`define AGC_ULIMIT      13'h00C
`define AGC_LLIMIT      13'h010

// Live integrator value. Read only.
`define AGC_INTEGRATOR  13'h014

`endif
